/* hdl/eeprom_consts.svh */
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// device type identifier of the 24C16 family
`define EEPROM_DEV_CODE 4'b1010

// CLK cycles per quarter scl period, 1 or more
// one bus bit takes four quarters
`define EEPROM_QTR_CLKS 2

// byte address into the 2 kB array
// bits 10 to 8 travel in the control byte
`define EEPROM_ADDR_W 11

`define EEPROM_DATA_W 8

`endif

/* hdl/eeprom_pkg.sv */
`include "eeprom_consts.svh"

package eeprom_pkg;

    typedef logic [`EEPROM_ADDR_W-1:0] ee_addr_t;   // byte address in the array
    typedef logic [`EEPROM_DATA_W-1:0] ee_byte_t;   // one bus byte
    typedef logic [3:0]                ee_qtr_t;    // clocks inside a quarter

    // bus steps run by the bit engine, start also serves as repeated start
    typedef enum logic [1:0] {
        STEP_START,
        STEP_WRITE,
        STEP_READ,
        STEP_STOP
    } ee_step_e;

    // transaction sequencer
    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RESTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP,
        S_DONE
    } ee_seq_e;

endpackage

/* hdl/eeprom_step_if.sv */
`timescale 1ns/10ps

// sequencer to bit engine, one step at a time
interface eeprom_step_if;

    logic                 step_go;     // one cycle, only while engine idle
    eeprom_pkg::ee_step_e step_kind;
    eeprom_pkg::ee_byte_t step_byte;
    logic                 step_done;   // last cycle of the step
    logic                 step_nack;   // valid with step_done of a write

    modport seq
    (
        output step_go,
        output step_kind,
        output step_byte,
        input  step_done,
        input  step_nack
    );

    modport eng
    (
        input  step_go,
        input  step_kind,
        input  step_byte,
        output step_done,
        output step_nack
    );

endinterface

// bit engine to result block
interface eeprom_rx_if;

    logic                 rx_valid;
    eeprom_pkg::ee_byte_t rx_byte;
    logic                 ack_seen;     // pulse per written byte
    logic                 ack_missing;

    modport eng (output rx_valid, output rx_byte, output ack_seen, output ack_missing);

    modport res (input rx_valid, input rx_byte, input ack_seen, input ack_missing);

endinterface

/* hdl/eeprom_cmd_decode.sv */
`timescale 1ns/10ps
`include "eeprom_consts.svh"

module eeprom_cmd_decode
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_byte_t wdata,
    eeprom_step_if.seq           step,
    output logic                 txn_end,
    output logic                 is_read
);

    eeprom_pkg::ee_seq_e  state;
    eeprom_pkg::ee_seq_e  nxt;
    eeprom_pkg::ee_addr_t addr_r;
    eeprom_pkg::ee_byte_t data_r;
    logic                 rd_r;
    logic                 move;
    logic                 issue;

    // device code, page bits, read/write bit
    function automatic eeprom_pkg::ee_byte_t ctrl_byte(input eeprom_pkg::ee_addr_t a,
                                                       input logic rnw);
        ctrl_byte = {`EEPROM_DEV_CODE, a[`EEPROM_ADDR_W-1:8], rnw};
    endfunction

    always_comb
    begin
        case (state)
            eeprom_pkg::S_IDLE:    nxt = (wr || rd) ? eeprom_pkg::S_START : eeprom_pkg::S_IDLE;
            eeprom_pkg::S_START:   nxt = eeprom_pkg::S_CTRL_W;
            eeprom_pkg::S_CTRL_W:  nxt = step.step_nack ? eeprom_pkg::S_STOP : eeprom_pkg::S_ADDR;
            eeprom_pkg::S_ADDR:
            begin
                if (step.step_nack)
                    nxt = eeprom_pkg::S_STOP;   // bail out, bus still released
                else if (rd_r)
                    nxt = eeprom_pkg::S_RESTART;
                else
                    nxt = eeprom_pkg::S_DATA_W;
            end
            eeprom_pkg::S_DATA_W:  nxt = eeprom_pkg::S_STOP;
            eeprom_pkg::S_RESTART: nxt = eeprom_pkg::S_CTRL_R;
            eeprom_pkg::S_CTRL_R:  nxt = step.step_nack ? eeprom_pkg::S_STOP : eeprom_pkg::S_DATA_R;
            eeprom_pkg::S_DATA_R:  nxt = eeprom_pkg::S_STOP;
            eeprom_pkg::S_STOP:    nxt = eeprom_pkg::S_DONE;
            default:               nxt = eeprom_pkg::S_IDLE;
        endcase
    end

    // idle waits for a request, done lasts one cycle, the rest wait on the engine
    always_comb
    begin
        case (state)
            eeprom_pkg::S_IDLE: move = wr || rd;
            eeprom_pkg::S_DONE: move = 1'b1;
            default:            move = step.step_done;
        endcase
    end

    assign issue = move && (nxt != eeprom_pkg::S_DONE) && (nxt != eeprom_pkg::S_IDLE);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state          <= eeprom_pkg::S_IDLE;
            rd_r           <= 1'b0;
            step.step_go   <= 1'b0;
            step.step_kind <= eeprom_pkg::STEP_STOP;
        end
        else
        begin
            step.step_go <= issue;
            if (move)
                state <= nxt;
            if ((state == eeprom_pkg::S_IDLE) && move)
                rd_r <= rd && !wr;   // write wins
            if (issue)
            begin
                case (nxt)
                    eeprom_pkg::S_START,
                    eeprom_pkg::S_RESTART: step.step_kind <= eeprom_pkg::STEP_START;
                    eeprom_pkg::S_DATA_R:  step.step_kind <= eeprom_pkg::STEP_READ;
                    eeprom_pkg::S_STOP:    step.step_kind <= eeprom_pkg::STEP_STOP;
                    default:               step.step_kind <= eeprom_pkg::STEP_WRITE;
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if ((state == eeprom_pkg::S_IDLE) && move)
        begin
            addr_r <= addr;
            data_r <= wdata;
        end
        if (issue)
        begin
            case (nxt)
                eeprom_pkg::S_CTRL_W: step.step_byte <= ctrl_byte(addr_r, 1'b0);
                eeprom_pkg::S_ADDR:   step.step_byte <= addr_r[7:0];
                eeprom_pkg::S_DATA_W: step.step_byte <= data_r;
                eeprom_pkg::S_CTRL_R: step.step_byte <= ctrl_byte(addr_r, 1'b1);
                default:              step.step_byte <= 8'hff;   // not shifted out
            endcase
        end
    end

    assign txn_end = (state == eeprom_pkg::S_DONE);   // one cycle after the stop
    assign is_read = rd_r;

endmodule

/* hdl/eeprom_bit_engine.sv */
`timescale 1ns/10ps
`include "eeprom_consts.svh"

module eeprom_bit_engine
(
    input  logic       CLK,
    input  logic       RESET,
    eeprom_step_if.eng step,
    eeprom_rx_if.eng   rx,
    output logic       scl,
    output logic       sda_out,
    output logic       sda_oe,
    input  logic       sda_in
);

    localparam eeprom_pkg::ee_qtr_t QTR_LAST = eeprom_pkg::ee_qtr_t'(`EEPROM_QTR_CLKS - 1);
    localparam logic [3:0]          ACK_BIT  = 4'd8;

    logic                 active;
    eeprom_pkg::ee_step_e kind;
    eeprom_pkg::ee_byte_t shreg;
    eeprom_pkg::ee_qtr_t  cnt;
    logic [1:0]           qtr;    // 0,1 scl low  2,3 scl high for data bits
    logic [3:0]           bitn;
    logic                 nack_r;
    logic                 qtr_end;
    logic                 one_bit;
    logic                 last_bit;

    assign qtr_end  = active && (cnt == QTR_LAST);
    assign one_bit  = (kind == eeprom_pkg::STEP_START) || (kind == eeprom_pkg::STEP_STOP);
    assign last_bit = one_bit || (bitn == ACK_BIT);

    assign step.step_done = qtr_end && (qtr == 2'd3) && last_bit;
    assign step.step_nack = nack_r;

    assign rx.rx_valid    = step.step_done && (kind == eeprom_pkg::STEP_READ);
    assign rx.rx_byte     = shreg;
    assign rx.ack_seen    = step.step_done && (kind == eeprom_pkg::STEP_WRITE);
    assign rx.ack_missing = nack_r;

    // quarter, bit and step tracking
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            kind   <= eeprom_pkg::STEP_STOP;
            cnt    <= '0;
            qtr    <= 2'd0;
            bitn   <= 4'd0;
        end
        else if (step.step_go)
        begin
            active <= 1'b1;
            kind   <= step.step_kind;
            cnt    <= '0;
            qtr    <= 2'd0;
            bitn   <= 4'd0;
        end
        else if (active)
        begin
            if (!qtr_end)
                cnt <= cnt + 4'd1;
            else
            begin
                cnt <= '0;
                qtr <= qtr + 2'd1;
                if (qtr == 2'd3)
                begin
                    if (last_bit)
                        active <= 1'b0;
                    else
                        bitn <= bitn + 4'd1;
                end
            end
        end
    end

    // bus levels, set on entry to each quarter and held between steps
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            sda_out <= 1'b1;
            nack_r  <= 1'b0;
        end
        else if (step.step_go)
        begin
            scl <= 1'b0;
            if (step.step_kind == eeprom_pkg::STEP_START)
                sda_oe <= 1'b0;   // release so the line can rise
        end
        else if (qtr_end)
        begin
            case (qtr)
                2'd0:
                begin
                    case (kind)
                        eeprom_pkg::STEP_START: scl <= 1'b1;
                        eeprom_pkg::STEP_STOP:
                        begin
                            sda_oe  <= 1'b1;
                            sda_out <= 1'b0;
                        end
                        eeprom_pkg::STEP_WRITE:
                        begin
                            sda_oe  <= (bitn != ACK_BIT);   // slave owns the ack bit
                            sda_out <= shreg[7];
                        end
                        default:
                        begin
                            sda_oe  <= (bitn == ACK_BIT);   // master nack, driven high
                            sda_out <= 1'b1;
                        end
                    endcase
                end
                2'd1:
                begin
                    if (kind == eeprom_pkg::STEP_START)
                    begin
                        sda_oe  <= 1'b1;   // falls under high scl
                        sda_out <= 1'b0;
                    end
                    else
                        scl <= 1'b1;
                end
                2'd2:
                begin
                    if (kind == eeprom_pkg::STEP_START)
                        scl <= 1'b0;
                    else if (kind == eeprom_pkg::STEP_STOP)
                        sda_oe <= 1'b0;   // stop condition
                    else if ((kind == eeprom_pkg::STEP_WRITE) && (bitn == ACK_BIT))
                        nack_r <= sda_in;
                end
                default:
                begin
                    if (!last_bit)
                        scl <= 1'b0;
                end
            endcase
        end
    end

    // one shifter for both directions, MSB first
    always_ff @(posedge CLK)
    begin
        if (step.step_go)
            shreg <= step.step_byte;
        else if (qtr_end && (qtr == 2'd2) && !one_bit && (bitn != ACK_BIT))
            shreg <= {shreg[6:0], sda_in};   // mid scl high
    end

endmodule

/* hdl/eeprom_read_result.sv */
`timescale 1ns/10ps

module eeprom_read_result
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 txn_end,
    input  logic                 is_read,
    eeprom_rx_if.res             rx,
    output eeprom_pkg::ee_byte_t rdata,
    output logic                 ack,
    output logic                 nack
);

    logic                 first;   // next ack_seen opens a transaction
    logic                 miss;
    logic                 got;
    eeprom_pkg::ee_byte_t rx_hold;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            first <= 1'b1;
            miss  <= 1'b0;
            got   <= 1'b0;
            ack   <= 1'b0;
            nack  <= 1'b0;
            rdata <= '0;
        end
        else
        begin
            ack <= txn_end;
            if (rx.ack_seen)
            begin
                first <= 1'b0;
                miss  <= rx.ack_missing || (miss && !first);   // sticky
            end
            if (rx.rx_valid)
                got <= 1'b1;
            if (txn_end)
            begin
                first <= 1'b1;
                got   <= 1'b0;
                nack  <= miss;
                if (is_read && got)
                    rdata <= rx_hold;   // cut short reads keep the old byte
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (rx.rx_valid)
            rx_hold <= rx.rx_byte;
    end

endmodule

/* hdl/eeprom_ctrl.sv */
`timescale 1ns/10ps

module eeprom_ctrl
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_byte_t wdata,
    input  logic                 sda_in,
    output eeprom_pkg::ee_byte_t rdata,
    output logic                 ack,
    output logic                 nack,
    output logic                 scl,
    output logic                 sda_out,
    output logic                 sda_oe
);

    logic txn_end;
    logic is_read;

    eeprom_step_if step_if_i ();
    eeprom_rx_if   rx_if_i ();

    eeprom_cmd_decode cmd_decode_i
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .step    (step_if_i),
        .txn_end (txn_end),
        .is_read (is_read)
    );

    eeprom_bit_engine bit_engine_i
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .step    (step_if_i),
        .rx      (rx_if_i),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .sda_in  (sda_in)
    );

    eeprom_read_result read_result_i
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .txn_end (txn_end),
        .is_read (is_read),
        .rx      (rx_if_i),
        .rdata   (rdata),
        .ack     (ack),
        .nack    (nack)
    );

endmodule

/* dv/eeprom_slave_model.sv */
`timescale 1ns/10ps

// 24C16 style slave sampling the bus on CLK
// one byte per write or read
module eeprom_slave_model
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic ack_off,
    output logic pull,       // open drain pull down
    output logic busy,       // between start and stop
    output int   rule_errs
);

    typedef enum logic [2:0] {P_IGNORE, P_CTRL, P_ADDR, P_WDATA, P_RDATA} phase_e;

    logic [7:0]  mem [0:2047];
    logic [10:0] ptr;
    logic [7:0]  shreg;
    logic [7:0]  txbyte;
    logic [3:0]  bitcnt;
    logic        scl_q;
    logic        sda_q;
    logic        take;
    phase_e      phase;
    int          errs = 0;

    assign rule_errs = errs;
    assign take      = !ack_off && ((phase == P_ADDR) || (phase == P_WDATA) ||
                       ((phase == P_CTRL) && (shreg[7:4] == 4'b1010)));

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q  <= 1'b1;
            sda_q  <= 1'b1;
            pull   <= 1'b0;
            busy   <= 1'b0;
            bitcnt <= 4'd0;
            phase  <= P_IGNORE;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && scl && (sda_q != sda))
            begin
                // start or stop is legal only in the first clock of a byte
                assert (bitcnt == 4'd1)
                else
                begin
                    errs++;
                    $display("SDA changed under high SCL in the middle of a byte at %0t", $time);
                end
                if (sda)
                begin
                    assert (busy)
                    else
                    begin
                        errs++;
                        $display("A stop condition came without a start at %0t", $time);
                    end
                end
                busy   <= !sda;
                phase  <= sda ? P_IGNORE : P_CTRL;
                bitcnt <= 4'd0;
                pull   <= 1'b0;
            end
            else if (!scl_q && scl)
            begin
                if (bitcnt == 4'd8)
                    bitcnt <= 4'd0;   // acknowledge clock
                else
                begin
                    shreg  <= {shreg[6:0], sda};
                    bitcnt <= bitcnt + 4'd1;
                end
            end
            else if (scl_q && !scl)
            begin
                pull <= (phase == P_RDATA) && !txbyte[~bitcnt[2:0]];
                if (bitcnt == 4'd8)
                begin
                    assert (busy)
                    else
                    begin
                        errs++;
                        $display("A byte was clocked without a start condition at %0t", $time);
                    end
                    pull  <= take;
                    phase <= P_IGNORE;
                    if (take)
                    begin
                        case (phase)
                            P_CTRL:
                            begin
                                ptr[10:8] <= shreg[3:1];   // page bits
                                txbyte    <= mem[{shreg[3:1], ptr[7:0]}];
                                phase     <= shreg[0] ? P_RDATA : P_ADDR;
                            end
                            P_ADDR:
                            begin
                                ptr[7:0] <= shreg;
                                phase    <= P_WDATA;
                            end
                            default: mem[ptr] <= shreg;
                        endcase
                    end
                end
            end
        end
    end

endmodule

/* dv/eeprom_ctrl_tb.sv */
`timescale 1ns/10ps
`include "eeprom_consts.svh"

module eeprom_ctrl_tb;

    localparam int NUM_TXN  = 27;
    localparam int BIT_CLKS = 4 * `EEPROM_QTR_CLKS;
    localparam int LIMIT_NS = (NUM_TXN * 60 + 40) * BIT_CLKS * 10;

    logic                 CLK = 1'b0;
    logic                 RESET;
    logic                 wr;
    logic                 rd;
    eeprom_pkg::ee_addr_t addr;
    eeprom_pkg::ee_byte_t wdata;
    eeprom_pkg::ee_byte_t rdata;
    logic                 ack;
    logic                 nack;
    logic                 scl;
    logic                 sda_out;
    logic                 sda_oe;
    logic                 sda_in;
    logic                 slave_pull;
    logic                 slave_busy;
    logic                 ack_off;
    int                   rule_errs;
    int                   errors = 0;
    int                   checks = 0;
    int                   ack_count = 0;
    int                   requests = 0;
    logic [31:0]          lcg = 32'd16877;
    eeprom_pkg::ee_byte_t last_rdata = 8'h00;
    eeprom_pkg::ee_byte_t ref_mem [0:2047];
    eeprom_pkg::ee_addr_t picks [8];

    // open drain line is low if either side pulls
    assign sda_in = !((sda_oe && !sda_out) || slave_pull);

    eeprom_ctrl eeprom_ctrl_i (.*);

    eeprom_slave_model slave_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda_in),
        .ack_off   (ack_off),
        .pull      (slave_pull),
        .busy      (slave_busy),
        .rule_errs (rule_errs)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        if (ack)
            ack_count <= ack_count + 1;
    end

    initial
    begin
        #(LIMIT_NS);
        $display("Timeout: the transactions did not complete within %0d ns", LIMIT_NS);
        $display("checks %0d, errors %0d, bus rule errors %0d", checks, errors, rule_errs);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        lcg = lcg * 32'd1103515245 + 32'd12345;
        return {8'd0, lcg[31:8]};
    endfunction

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        checks++;
        assert (expected === actual)
        else
        begin
            errors++;
            $display("mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic check_rule(input logic ok, input string what);
        checks++;
        assert (ok)
        else
        begin
            errors++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    // one request, optional rd pulse while busy, then wait for ack
    task automatic run_txn(input logic do_wr, input logic do_rd, input logic poke,
                           input eeprom_pkg::ee_addr_t a, input eeprom_pkg::ee_byte_t d);
        compare_value("ack pulses", 16'(requests), 16'(ack_count));
        check_rule(scl && !sda_oe && !ack, "bus was not idle before a request");
        wr    = do_wr;
        rd    = do_rd;
        addr  = a;
        wdata = d;
        requests++;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        if (poke)
        begin
            repeat (20) @(negedge CLK);
            rd = 1'b1;
            @(negedge CLK);
            rd = 1'b0;
        end
        while (!ack)
            @(negedge CLK);
        compare_value("nack", 16'(ack_off), 16'(nack));
        compare_value("rdata", 16'(last_rdata), 16'(rdata));
        check_rule(!slave_busy && scl && sda_in, "transaction did not end with a stop");
        @(negedge CLK);
    endtask

    task automatic write_byte(input eeprom_pkg::ee_addr_t a, input eeprom_pkg::ee_byte_t d,
                              input logic with_rd, input logic poke);
        run_txn(1'b1, with_rd, poke, a, d);   // rdata stays
        if (!ack_off)
            ref_mem[a] = d;
    endtask

    task automatic read_byte(input eeprom_pkg::ee_addr_t a);
        if (!ack_off)
            last_rdata = ref_mem[a];
        run_txn(1'b0, 1'b1, 1'b0, a, 8'h00);
    endtask

    initial
    begin
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wdata   = '0;
        ack_off = 1'b0;
        repeat (3) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check_rule(scl && !sda_oe && !ack && !nack, "bus or status not idle after reset");

        for (int i = 0; i < 8; i++)
        begin
            picks[i] = eeprom_pkg::ee_addr_t'(next_rand());
            write_byte(picks[i], eeprom_pkg::ee_byte_t'(next_rand()), 1'b0, 1'b0);
        end
        for (int i = 0; i < 8; i++)
            read_byte(picks[i]);

        // same low byte on two pages
        write_byte({3'b010, picks[0][7:0]}, 8'h5a, 1'b0, 1'b0);
        write_byte({3'b101, picks[0][7:0]}, 8'ha5, 1'b0, 1'b0);
        read_byte({3'b010, picks[0][7:0]});
        read_byte({3'b101, picks[0][7:0]});

        ack_off = 1'b1;
        write_byte(picks[1], ~ref_mem[picks[1]], 1'b0, 1'b0);
        read_byte(picks[2]);
        ack_off = 1'b0;
        read_byte(picks[1]);   // old byte survives

        write_byte(picks[3], ~ref_mem[picks[3]], 1'b1, 1'b0);   // wr beats rd
        read_byte(picks[3]);

        write_byte(picks[4], eeprom_pkg::ee_byte_t'(next_rand()), 1'b0, 1'b1);
        repeat (12 * BIT_CLKS) @(negedge CLK);
        check_rule(scl && !sda_oe && !slave_busy, "a request raised while busy was run");
        read_byte(picks[4]);
        compare_value("ack pulses", 16'(requests), 16'(ack_count));

        $display("checks %0d, errors %0d, bus rule errors %0d", checks, errors, rule_errs);
        if ((errors == 0) && (rule_errs == 0))
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
hdl/eeprom_pkg.sv
hdl/eeprom_step_if.sv
hdl/eeprom_cmd_decode.sv
hdl/eeprom_bit_engine.sv
hdl/eeprom_read_result.sv
hdl/eeprom_ctrl.sv
dv/eeprom_slave_model.sv
dv/eeprom_ctrl_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = eeprom_ctrl_tb
FILELIST  = compile.f
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
